//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_pic
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/pic_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module pic_arbiter
   import pic_irq_pkg::*;
#(
   parameter int NUM_SRC = 32
) (
   input  logic    clk,
   input  logic    arst_n,
   input  prio_t   meipt,
   input  prio_t   meicurpl,
   output irq_id_t claimid,
   output prio_t   pl,
   output logic    mexintpend,
   output logic    mhwakeup,
   pic_cfg_if.arb  cfg
);

   localparam int LEVELS   = $clog2(NUM_SRC);
   localparam int NUM_LEAF = 2 ** LEVELS;

   prio_t   win_pl;
   irq_id_t win_id;
   prio_t   pl_d;
   prio_t   meipt_eff;
   prio_t   curpl_eff;
   prio_t   max_pl;
   logic    pend_d;
   logic    wake_d;

   ////////////////////
   // Comparison tree
   for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
      prio_t   lvl_pl [0:(NUM_LEAF >> l)-1];
      irq_id_t lvl_id [0:(NUM_LEAF >> l)-1];

      if (l == 0) begin : g_leaf
         for (genvar i = 0; i < NUM_LEAF; i++) begin : g_in
            if (i < NUM_SRC) begin : g_src
               prio_t lvl;

               assign lvl       = cfg.order_rev ? ~cfg.prio[i] : cfg.prio[i];
               assign lvl_pl[i] = (cfg.pending[i] & cfg.enable[i]) ? lvl : '0;
               assign lvl_id[i] = irq_id_t'(i);
            end else begin : g_pad
               assign lvl_pl[i] = '0;             // Never beats a real source
               assign lvl_id[i] = '0;
            end
         end
      end else begin : g_cmp
         for (genvar m = 0; m < (NUM_LEAF >> l); m++) begin : g_node
            logic take_b;

            // Left side has the lower ids and wins ties
            assign take_b    = g_lvl[l-1].lvl_pl[2*m] < g_lvl[l-1].lvl_pl[2*m+1];
            assign lvl_pl[m] = take_b ? g_lvl[l-1].lvl_pl[2*m+1] : g_lvl[l-1].lvl_pl[2*m];
            assign lvl_id[m] = take_b ? g_lvl[l-1].lvl_id[2*m+1] : g_lvl[l-1].lvl_id[2*m];
         end
      end
   end

   assign win_pl = g_lvl[LEVELS].lvl_pl[0];
   assign win_id = g_lvl[LEVELS].lvl_id[0];

   ////////////////////
   // Notification
   assign meipt_eff = cfg.order_rev ? ~meipt : meipt;
   assign curpl_eff = cfg.order_rev ? ~meicurpl : meicurpl;
   assign pl_d      = cfg.order_rev ? ~win_pl : win_pl;     // Back to software levels
   assign max_pl    = cfg.order_rev ? prio_t'(0) : PRIO_MAX;
   assign pend_d    = (win_pl > meipt_eff) && (win_pl > curpl_eff);
   assign wake_d    = (pl_d == max_pl);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= win_id;
         pl         <= pl_d;
         mexintpend <= pend_d;
         mhwakeup   <= wake_d;
      end
   end

   a_claim_range : assert property (@(posedge clk) disable iff (!arst_n)
      claimid < NUM_SRC);

endmodule

`default_nettype wire

//--- rtl/pic_bus_pkg.sv
`default_nettype none

package pic_bus_pkg;

   localparam int WB_ADDR_W  = 16;
   localparam int WB_DATA_W  = 32;
   localparam int REGION_LSB = 12;            // Top nibble selects the region

   ////////////////////
   // Register map
   localparam logic [WB_ADDR_W-1:0] PRIORITY_BASE  = 16'h0000;
   localparam logic [WB_ADDR_W-1:0] PENDING_BASE   = 16'h1000;
   localparam logic [WB_ADDR_W-1:0] ENABLE_BASE    = 16'h2000;
   localparam logic [WB_ADDR_W-1:0] CONFIG_ADDR    = 16'h3000;
   localparam logic [WB_ADDR_W-1:0] GW_CONFIG_BASE = 16'h4000;
   localparam logic [WB_ADDR_W-1:0] GW_CLEAR_BASE  = 16'h5000;

   ////////////////////
   // Data word views
   typedef struct packed {
      logic [WB_DATA_W-5:0] rsvd;
      logic [3:0]           prio;
   } pic_prio_view_t;

   typedef struct packed {
      logic [WB_DATA_W-3:0] rsvd;
      logic                 gw_type;          // 1 is edge
      logic                 polarity;         // 1 is active low
   } pic_gw_view_t;

   // Same word, read per address region
   typedef union packed {
      pic_prio_view_t pri;
      pic_gw_view_t   gw;
   } pic_reg_word_u;

endpackage

`default_nettype wire

//--- rtl/pic_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

interface pic_cfg_if
   import pic_irq_pkg::*;
#(
   parameter int NUM_SRC = 32
);

   prio_t [NUM_SRC-1:0] prio;
   logic  [NUM_SRC-1:0] enable;
   logic  [NUM_SRC-1:0] gw_polarity;
   logic  [NUM_SRC-1:0] gw_edge;
   logic  [NUM_SRC-1:0] gw_clear;       // One cycle per clear write
   logic                order_rev;      // 0 becomes most urgent
   logic  [NUM_SRC-1:0] pending;

   modport regs (
      output prio,
      output enable,
      output gw_polarity,
      output gw_edge,
      output gw_clear,
      output order_rev,
      input  pending
   );

   modport gw (
      input  gw_polarity,
      input  gw_edge,
      input  gw_clear,
      output pending
   );

   modport arb (
      input  prio,
      input  enable,
      input  order_rev,
      input  pending
   );

endinterface

`default_nettype wire

//--- rtl/pic_gateways.sv
`timescale 1ns/100ps
`default_nettype none

module pic_gateways
   import pic_irq_pkg::*;
#(
   parameter int NUM_SRC = 32
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic [NUM_SRC-1:0] ext_irq,
   pic_cfg_if.gw              cfg
);

   localparam irq_id_t LAST_SRC = irq_id_t'(NUM_SRC - 1);

   logic [NUM_SRC-1:1] sync_q1;
   logic [NUM_SRC-1:1] sync_q2;
   logic [NUM_SRC-1:0] pend;

   // Two-flop synchronizer, bit 0 unused
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= ext_irq[NUM_SRC-1:1];
         sync_q2 <= sync_q1;
      end
   end

   ////////////////////
   // Per-source gateway
   for (genvar i = 1; i <= LAST_SRC; i++) begin : g_src
      logic act;
      logic sticky_q;

      assign act = sync_q2[i] ^ cfg.gw_polarity[i];

      // Held until cleared, reloads while input still active
      always_ff @(posedge clk or negedge arst_n) begin
         if (!arst_n) begin
            sticky_q <= 1'b0;
         end else begin
            sticky_q <= cfg.gw_edge[i] & (act | (sticky_q & ~cfg.gw_clear[i]));
         end
      end

      assign pend[i] = act | (cfg.gw_edge[i] & sticky_q);
   end

   assign pend[0]     = 1'b0;                // Reserved source
   assign cfg.pending = pend;

   a_no_clear_src0 : assert property (@(posedge clk) disable iff (!arst_n)
      !cfg.gw_clear[0]);

endmodule

`default_nettype wire

//--- rtl/pic_irq_pkg.sv
`default_nettype none

package pic_irq_pkg;

   ////////////////////
   // Widths
   localparam int PRIO_W = 4;
   localparam int ID_W   = 8;                 // Up to 255 sources

   typedef logic [PRIO_W-1:0] prio_t;
   typedef logic [ID_W-1:0]   irq_id_t;

   // Most urgent level in normal order
   localparam prio_t PRIO_MAX = 4'd15;

endpackage

`default_nettype wire

//--- rtl/pic_regs.sv
`timescale 1ns/100ps
`default_nettype none

module pic_regs
   import pic_bus_pkg::*;
   import pic_irq_pkg::*;
#(
   parameter int NUM_SRC = 32
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [WB_ADDR_W-1:0] wb_adr,
   input  logic [WB_DATA_W-1:0] wb_dat_w,
   output logic [WB_DATA_W-1:0] wb_dat_r,
   output logic                 wb_ack,
   pic_cfg_if.regs              cfg
);

   localparam int NUM_GRP = (NUM_SRC + WB_DATA_W - 1) / WB_DATA_W;

   logic                              req;
   logic                              wr;
   logic [WB_ADDR_W-REGION_LSB-1:0]   region;
   irq_id_t                           src_idx;
   logic                              word_ok;
   logic                              src_ok;
   logic                              grp_ok;
   logic                              hit_prio;
   logic                              hit_pend;
   logic                              hit_en;
   logic                              hit_cfg;
   logic                              hit_gw;
   logic                              hit_clr;
   pic_reg_word_u                     wdat;
   pic_reg_word_u                     rd_word;
   logic [NUM_GRP*WB_DATA_W-1:0]      pend_ext;

   prio_t [NUM_SRC-1:1]               prio_q;
   logic  [NUM_SRC-1:1]               enable_q;
   logic  [NUM_SRC-1:1]               pol_q;
   logic  [NUM_SRC-1:1]               edge_q;
   logic  [NUM_SRC-1:1]               clr_q;
   logic                              order_q;

   ////////////////////
   // Address decode
   assign req     = wb_cyc & wb_stb & ~wb_ack;   // Idle cycle after every ack
   assign wr      = req & wb_we;
   assign region  = wb_adr[WB_ADDR_W-1:REGION_LSB];
   assign src_idx = wb_adr[9:2];
   assign word_ok = (wb_adr[11:10] == 2'b00) && (wb_adr[1:0] == 2'b00);
   assign src_ok  = word_ok && (src_idx != '0) && (src_idx < NUM_SRC);
   assign grp_ok  = word_ok && (src_idx < NUM_GRP);
   assign wdat    = wb_dat_w;

   assign hit_prio = (region == PRIORITY_BASE[WB_ADDR_W-1:REGION_LSB]) && src_ok;
   assign hit_pend = (region == PENDING_BASE[WB_ADDR_W-1:REGION_LSB]) && grp_ok;
   assign hit_en   = (region == ENABLE_BASE[WB_ADDR_W-1:REGION_LSB]) && src_ok;
   assign hit_gw   = (region == GW_CONFIG_BASE[WB_ADDR_W-1:REGION_LSB]) && src_ok;
   assign hit_clr  = (region == GW_CLEAR_BASE[WB_ADDR_W-1:REGION_LSB]) && src_ok;
   assign hit_cfg  = (wb_adr == CONFIG_ADDR);

   ////////////////////
   // Registers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack   <= 1'b0;
         prio_q   <= '0;
         enable_q <= '0;
         pol_q    <= '0;
         edge_q   <= '0;
         clr_q    <= '0;
         order_q  <= 1'b0;
      end else begin
         wb_ack <= req;
         clr_q  <= '0;
         if (wr && hit_prio) begin
            prio_q[src_idx] <= wdat.pri.prio;
         end
         if (wr && hit_en) begin
            enable_q[src_idx] <= wb_dat_w[0];
         end
         if (wr && hit_gw) begin
            pol_q[src_idx]  <= wdat.gw.polarity;
            edge_q[src_idx] <= wdat.gw.gw_type;
         end
         if (wr && hit_clr) begin
            clr_q[src_idx] <= 1'b1;                 // Data ignored
         end
         if (wr && hit_cfg) begin
            order_q <= wb_dat_w[0];
         end
      end
   end

   ////////////////////
   // Read mux
   always_comb begin
      pend_ext              = '0;
      pend_ext[NUM_SRC-1:0] = cfg.pending;
      rd_word               = '0;
      if (hit_prio) begin
         rd_word.pri.prio = prio_q[src_idx];
      end else if (hit_pend) begin
         rd_word = pend_ext[int'(src_idx)*WB_DATA_W +: WB_DATA_W];
      end else if (hit_en) begin
         rd_word = {{(WB_DATA_W-1){1'b0}}, enable_q[src_idx]};
      end else if (hit_gw) begin
         rd_word.gw.polarity = pol_q[src_idx];
         rd_word.gw.gw_type  = edge_q[src_idx];
      end else if (hit_cfg) begin
         rd_word = {{(WB_DATA_W-1){1'b0}}, order_q};
      end
   end

   always_ff @(posedge clk) begin
      if (req && !wb_we) begin
         wb_dat_r <= rd_word;
      end
   end

   // Source 0 has no registers
   assign cfg.prio        = {prio_q, prio_t'(0)};
   assign cfg.enable      = {enable_q, 1'b0};
   assign cfg.gw_polarity = {pol_q, 1'b0};
   assign cfg.gw_edge     = {edge_q, 1'b0};
   assign cfg.gw_clear    = {clr_q, 1'b0};
   assign cfg.order_rev   = order_q;

   a_ack_single : assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack);

   a_ack_after_req : assert property (@(posedge clk) disable iff (!arst_n)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule

`default_nettype wire

//--- rtl/pic_top.sv
`timescale 1ns/100ps
`default_nettype none

module pic_top
   import pic_bus_pkg::*;
   import pic_irq_pkg::*;
#(
   parameter int NUM_SRC = 32
) (
   input  logic                 clk,
   input  logic                 arst_n,

   // Wishbone slave
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [WB_ADDR_W-1:0] wb_adr,
   input  logic [WB_DATA_W-1:0] wb_dat_w,
   output logic [WB_DATA_W-1:0] wb_dat_r,
   output logic                 wb_ack,

   input  logic [NUM_SRC-1:0]   ext_irq,      // Bit 0 ignored
   input  prio_t                meipt,
   input  prio_t                meicurpl,

   output logic                 mexintpend,
   output irq_id_t              claimid,
   output prio_t                pl,
   output logic                 mhwakeup
);

   pic_cfg_if #(.NUM_SRC(NUM_SRC)) u_cfg ();

   pic_regs #(.NUM_SRC(NUM_SRC)) u_regs (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .cfg      (u_cfg.regs)
   );

   pic_gateways #(.NUM_SRC(NUM_SRC)) u_gw (
      .clk     (clk),
      .arst_n  (arst_n),
      .ext_irq (ext_irq),
      .cfg     (u_cfg.gw)
   );

   pic_arbiter #(.NUM_SRC(NUM_SRC)) u_arb (
      .clk        (clk),
      .arst_n     (arst_n),
      .meipt      (meipt),
      .meicurpl   (meicurpl),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup),
      .cfg        (u_cfg.arb)
   );

endmodule

`default_nettype wire

//--- sim/tb_pic.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pic
   import pic_bus_pkg::*;
   import pic_irq_pkg::*;
();

   localparam int NUM_SRC     = 32;
   localparam int ACK_TIMEOUT = 20;

   logic                 clk;
   logic                 arst_n;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   logic [WB_ADDR_W-1:0] wb_adr;
   logic [WB_DATA_W-1:0] wb_dat_w;
   logic [WB_DATA_W-1:0] wb_dat_r;
   logic                 wb_ack;
   logic [NUM_SRC-1:0]   ext_irq;
   prio_t                meipt;
   prio_t                meicurpl;
   logic                 mexintpend;
   irq_id_t              claimid;
   prio_t                pl;
   logic                 mhwakeup;

   logic [31:0]          seed;
   int                   errors;
   int                   timeouts;
   int                   checks;

   // Reference model state
   prio_t                m_prio   [NUM_SRC];
   logic                 m_en     [NUM_SRC];
   logic                 m_pol    [NUM_SRC];
   logic                 m_edge   [NUM_SRC];
   logic                 m_sticky [NUM_SRC];
   logic                 m_order;

   pic_top #(.NUM_SRC(NUM_SRC)) u_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .ext_irq    (ext_irq),
      .meipt      (meipt),
      .meicurpl   (meicurpl),
      .mexintpend (mexintpend),
      .claimid    (claimid),
      .pl         (pl),
      .mhwakeup   (mhwakeup)
   );

   always #50 clk = ~clk;

   ////////////////////
   // Helpers
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[31:16], lo[31:16]};               // Upper LCG bits only
   endfunction

   function automatic logic [15:0] src_adr(input logic [15:0] base, input int src);
      return base + 16'(src * 4);
   endfunction

   function automatic logic model_pend(input int i);
      logic act;
      act = ext_irq[i] ^ m_pol[i];
      return (i != 0) && (act || (m_edge[i] && m_sticky[i]));
   endfunction

   function automatic logic [31:0] model_pend_word();
      logic [31:0] w;
      w = '0;
      for (int i = 1; i < NUM_SRC; i++) begin
         w[i] = model_pend(i);
      end
      return w;
   endfunction

   // Edge latches follow the settled inputs
   function automatic void model_step();
      for (int i = 1; i < NUM_SRC; i++) begin
         if (!m_edge[i]) begin
            m_sticky[i] = 1'b0;
         end else if (ext_irq[i] ^ m_pol[i]) begin
            m_sticky[i] = 1'b1;
         end
      end
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s, expected %h, got %h", $time, msg, exp, got);
      end
   endtask

   task automatic settle();
      repeat (4) @(posedge clk);
      @(negedge clk);
   endtask

   ////////////////////
   // Wishbone master
   task automatic wb_access(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int n;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      n = 0;
      @(negedge clk);
      while (!wb_ack && n < ACK_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!wb_ack) begin
         timeouts++;
         $display("Timeout: no bus acknowledge for address %h", adr);
      end
      rdat = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [15:0] adr, input logic [31:0] d);
      logic [31:0] unused;
      wb_access(1'b1, adr, d, unused);
   endtask

   task automatic wb_read(input logic [15:0] adr, output logic [31:0] d);
      wb_access(1'b0, adr, '0, d);
   endtask

   task automatic write_reg(input logic [15:0] adr, input logic [31:0] d);
      int idx;
      idx = int'(adr[6:2]);
      wb_write(adr, d);
      if ((adr & 16'hf000) == CONFIG_ADDR) begin
         m_order = d[0];
      end else if (idx != 0) begin
         case (adr & 16'hf000)
            PRIORITY_BASE:  m_prio[idx] = d[3:0];
            ENABLE_BASE:    m_en[idx] = d[0];
            GW_CONFIG_BASE: begin
               m_pol[idx]  = d[0];
               m_edge[idx] = d[1];
            end
            GW_CLEAR_BASE:  m_sticky[idx] = m_sticky[idx] & (ext_irq[idx] ^ m_pol[idx]);
            default: ;
         endcase
      end
      model_step();
   endtask

   task automatic drive_irq(input logic [31:0] v);
      @(posedge clk);
      ext_irq <= v;
      settle();
      model_step();
   endtask

   task automatic check_pending(input int s, input logic exp_bit, input string msg);
      logic [31:0] rdat;
      wb_read(PENDING_BASE, rdat);
      check(rdat, model_pend_word(), {msg, " word"});
      check(32'(rdat[s]), 32'(exp_bit), msg);
   endtask

   task automatic check_outputs(input string tag);
      prio_t lvl;
      prio_t best;
      prio_t exp_pl;
      prio_t thr;
      prio_t cur;
      int    best_id;
      best    = '0;
      best_id = 0;
      for (int i = 1; i < NUM_SRC; i++) begin
         lvl = m_order ? ~m_prio[i] : m_prio[i];
         if (model_pend(i) && m_en[i] && lvl > best) begin    // Ties keep lower id
            best    = lvl;
            best_id = i;
         end
      end
      exp_pl = m_order ? ~best : best;
      thr    = m_order ? ~meipt : meipt;
      cur    = m_order ? ~meicurpl : meicurpl;
      check(32'(claimid), 32'(best_id), {tag, " claimid"});
      check(32'(pl), 32'(exp_pl), {tag, " pl"});
      check(32'(mexintpend), 32'(best > thr && best > cur), {tag, " mexintpend"});
      check(32'(mhwakeup), 32'(exp_pl == (m_order ? 4'd0 : PRIO_MAX)), {tag, " mhwakeup"});
   endtask

   task automatic arb_round(input string tag);
      int src;
      for (int k = 0; k < 6; k++) begin
         src = 1 + int'(rand_word() % 31);
         write_reg(src_adr(PRIORITY_BASE, src), rand_word());
         src = 1 + int'(rand_word() % 31);
         write_reg(src_adr(ENABLE_BASE, src), rand_word());
      end
      @(posedge clk);
      ext_irq  <= rand_word();
      meipt    <= 4'(rand_word());
      meicurpl <= 4'(rand_word());
      settle();
      model_step();
      check_outputs(tag);
   endtask

   ////////////////////
   // Main sequence
   initial begin
      logic [31:0] rdat;
      logic [31:0] d;
      logic [31:0] exp;
      logic [15:0] adr;
      int          src;
      clk      = 1'b0;
      arst_n   = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      ext_irq  = '0;
      meipt    = '0;
      meicurpl = '0;
      seed     = 32'hbddd0b4a;
      errors   = 0;
      timeouts = 0;
      checks   = 0;
      m_order  = 1'b0;
      for (int i = 0; i < NUM_SRC; i++) begin
         m_prio[i]   = '0;
         m_en[i]     = 1'b0;
         m_pol[i]    = 1'b0;
         m_edge[i]   = 1'b0;
         m_sticky[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      settle();
      check(32'(wb_ack), 32'd0, "reset wb_ack");
      check(32'(mexintpend), 32'd0, "reset mexintpend");
      check(32'(claimid), 32'd0, "reset claimid");
      check(32'(pl), 32'd0, "reset pl");
      check(32'(mhwakeup), 32'd0, "reset mhwakeup");

      // Register readback
      for (int k = 0; k < 40; k++) begin
         src = 1 + int'(rand_word() % 31);
         d   = rand_word();
         case (rand_word() % 4)
            0: begin
               adr = src_adr(PRIORITY_BASE, src);
               exp = d & 32'hf;
            end
            1: begin
               adr = src_adr(ENABLE_BASE, src);
               exp = d & 32'h1;
            end
            2: begin
               adr = src_adr(GW_CONFIG_BASE, src);
               exp = d & 32'h3;
            end
            default: begin
               adr = CONFIG_ADDR;
               exp = d & 32'h1;
            end
         endcase
         write_reg(adr, d);
         wb_read(adr, rdat);
         check(rdat, exp, $sformatf("readback %h", adr));
      end
      write_reg(PRIORITY_BASE, 32'hf);
      wb_read(PRIORITY_BASE, rdat);
      check(rdat, 32'd0, "source 0 priority");
      wb_write(16'h6000, 32'hffffffff);
      wb_read(16'h6000, rdat);
      check(rdat, 32'd0, "unmapped 6000");
      wb_read(16'h0c04, rdat);
      check(rdat, 32'd0, "unmapped 0c04");
      wb_read(16'h1004, rdat);
      check(rdat, 32'd0, "pending word 1");

      // Level gateways
      for (int i = 1; i < NUM_SRC; i++) begin
         write_reg(src_adr(GW_CONFIG_BASE, i), rand_word() & 32'h1);
      end
      for (int k = 0; k < 10; k++) begin
         drive_irq(rand_word());
         wb_read(PENDING_BASE, rdat);
         check(rdat, model_pend_word(), "level pending");
      end

      // Edge gateways
      for (int k = 0; k < 3; k++) begin
         src = 1 + int'(rand_word() % 31);
         write_reg(src_adr(GW_CONFIG_BASE, src), 32'h2);     // Edge, active high
         drive_irq(ext_irq & ~(32'h1 << src));
         write_reg(src_adr(GW_CLEAR_BASE, src), 32'h0);
         settle();
         check_pending(src, 1'b0, "edge idle");
         drive_irq(ext_irq | (32'h1 << src));
         drive_irq(ext_irq & ~(32'h1 << src));
         check_pending(src, 1'b1, "edge held");
         write_reg(src_adr(GW_CLEAR_BASE, src), rand_word());
         settle();
         check_pending(src, 1'b0, "edge cleared");
         drive_irq(ext_irq | (32'h1 << src));
         write_reg(src_adr(GW_CLEAR_BASE, src), rand_word());
         settle();
         drive_irq(ext_irq & ~(32'h1 << src));
         check_pending(src, 1'b1, "clear while asserted");
         write_reg(src_adr(GW_CLEAR_BASE, src), 32'h0);
         settle();
         check_pending(src, 1'b0, "edge cleared after drop");
      end

      // Arbitration, normal order
      write_reg(CONFIG_ADDR, 32'h0);
      repeat (12) arb_round("normal");
      for (int i = 1; i < NUM_SRC; i++) begin
         write_reg(src_adr(ENABLE_BASE, i), 32'h0);
      end
      settle();
      check(32'(claimid), 32'd0, "idle claimid");
      check(32'(pl), 32'd0, "idle pl");

      // Reversed order, then normal again
      write_reg(CONFIG_ADDR, 32'h1);
      repeat (15) arb_round("reversed");
      write_reg(CONFIG_ADDR, 32'h0);
      repeat (15) arb_round("normal notify");

      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
rtl/pic_bus_pkg.sv
rtl/pic_irq_pkg.sv
rtl/pic_cfg_if.sv
rtl/pic_regs.sv
rtl/pic_gateways.sv
rtl/pic_arbiter.sv
rtl/pic_top.sv
sim/tb_pic.sv
